//--- filelist.f
+incdir+include
rtl/bp_pkg.sv
rtl/bp_request_stage.sv
rtl/bp_predictor_core.sv
rtl/bp_response_stage.sv
rtl/tournament_predictor.sv
verif/tournament_predictor_assert.sv
verif/tb_tournament_predictor.sv

//--- run.sh
#!/bin/sh
# build and run the tournament predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_tournament_predictor \
    --Mdir obj_dir -o sim_tb -f filelist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- verif/tb_tournament_predictor.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module tb_tournament_predictor;

    import bp_pkg::*;

    localparam int CYCLE_LIMIT = 30000; // ~2500 transactions at up to 12 cycles
    localparam int ROUNDS      = 250;

    logic     clock = 1'b0;
    logic     reset;
    logic     req_valid;
    pc_t      req_pc;
    logic     req_ready;
    logic     resp_valid;
    pc_t      resp_pc;
    logic     resp_taken;
    logic     resp_gshare_taken;
    logic     resp_simple_taken;
    history_t resp_history;
    logic     resp_ready;
    logic     resolve_valid;
    pc_t      resolve_pc;
    history_t resolve_history;
    logic     resolve_taken;
    logic     resolve_predicted;
    logic     resolve_gshare_taken;
    logic     resolve_simple_taken;

    // reference model state
    logic [1:0] ref_gshare [`BP_PHT_ENTRIES];
    logic [1:0] ref_simple [`BP_PHT_ENTRIES];
    logic [1:0] ref_meta   [`BP_PHT_ENTRIES];
    history_t   model_history;

    pc_t      pending[$];     // accepted but not yet answered
    pc_t      log_pc[$];      // answered and waiting for a resolve
    history_t log_hist[$];
    logic     log_pred[$];
    logic     log_g[$];
    logic     log_s[$];

    int       accepted;
    int       responses;
    int       dropped;
    int       cycle_count = 0;
    logic     last_req_fire;
    logic     first_resp;
    logic     repair_pending;
    history_t repair_value;

    tournament_predictor i_dut (.*);

    always #4 clock = ~clock;  // 8 ns

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles", cycle_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("ERROR %s expected %0h actual %0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic fail_now(input string what);
        assert (1'b0) else begin
            $display("%s", what);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s", what);
        end
    endtask

    function automatic logic [1:0] toward(input logic [1:0] ctr, input logic up);
        if (up) return (ctr == 2'd3) ? 2'd3 : ctr + 2'd1;
        return (ctr == 2'd0) ? 2'd0 : ctr - 2'd1;
    endfunction

    function automatic pc_t random_pc();
        // small pool where upper bits differ but the table index aliases
        return pc_t'((($urandom % 4) << 24) | ($urandom % 6));
    endfunction

    // expected prediction from live model tables and then the speculative shift
    task automatic check_response();
        pht_index_t idx_s;
        pht_index_t idx_g;
        logic       g;
        logic       s;
        logic       t;
        if (pending.size() == 0) fail_now("response arrived with no request in flight");
        check_equal("resp_pc", pending.pop_front(), resp_pc);
        idx_s = resp_pc[`BP_PHT_INDEX_BITS-1:0];
        idx_g = idx_s ^ model_history;
        g = ref_gshare[idx_g][1];
        s = ref_simple[idx_s][1];
        t = ref_meta[idx_s][1] ? g : s;
        if (first_resp) begin
            check_equal("reset_taken", 0, 32'(resp_taken));
            check_equal("reset_history", 0, 32'(resp_history));
            first_resp = 1'b0;
        end
        if (repair_pending) begin
            check_equal("repair", 32'(repair_value), 32'(resp_history));
            repair_pending = 1'b0;
        end
        check_equal("resp_history", 32'(model_history), 32'(resp_history));
        check_equal("resp_gshare_taken", 32'(g), 32'(resp_gshare_taken));
        check_equal("resp_simple_taken", 32'(s), 32'(resp_simple_taken));
        check_equal("resp_taken", 32'(t), 32'(resp_taken));
        model_history = {model_history[`BP_HISTORY_BITS-2:0], t};
        log_pc.push_back(resp_pc);
        log_hist.push_back(resp_history);
        log_pred.push_back(t);
        log_g.push_back(g);
        log_s.push_back(s);
        responses++;
    endtask

    task automatic train_model();
        pht_index_t idx_s;
        pht_index_t idx_g;
        logic       g_right;
        logic       s_right;
        idx_s = resolve_pc[`BP_PHT_INDEX_BITS-1:0];
        idx_g = idx_s ^ resolve_history;
        g_right = (resolve_gshare_taken == resolve_taken);
        s_right = (resolve_simple_taken == resolve_taken);
        ref_gshare[idx_g] = toward(ref_gshare[idx_g], resolve_taken);
        ref_simple[idx_s] = toward(ref_simple[idx_s], resolve_taken);
        if (g_right != s_right) ref_meta[idx_s] = toward(ref_meta[idx_s], g_right);
        if (resolve_taken != resolve_predicted) begin
            model_history  = {resolve_history[`BP_HISTORY_BITS-2:0], resolve_taken};
            repair_pending = 1'b1;
            repair_value   = model_history;
            dropped += pending.size();   // both stages squashed
            pending.delete();
        end
    endtask

    // entered at a falling edge with inputs set and returns at the next one
    task automatic tick();
        logic req_fire;
        logic resp_fire;
        #2;
        req_fire  = req_valid && req_ready;
        resp_fire = resp_valid && resp_ready;
        if (resp_fire) check_response();
        if (req_fire) begin
            pending.push_back(req_pc);
            accepted++;
        end
        if (resolve_valid) train_model();
        @(negedge clock);
        resolve_valid = 1'b0;
        last_req_fire = req_fire;
        if (req_fire) req_valid = 1'b0;
    endtask

    task automatic resolve_oldest();
        resolve_pc           = log_pc.pop_front();
        resolve_history      = log_hist.pop_front();
        resolve_predicted    = log_pred.pop_front();
        resolve_gshare_taken = log_g.pop_front();
        resolve_simple_taken = log_s.pop_front();
        resolve_taken        = 1'($urandom % 2);
        resolve_valid        = 1'b1;
        tick();
    endtask

    task automatic serial_round();
        int target;
        target    = responses + 1;
        req_pc    = random_pc();
        req_valid = 1'b1;
        while (!last_req_fire) begin
            resp_ready = 1'($urandom % 2);
            tick();
        end
        while (responses < target) begin
            resp_ready = 1'($urandom % 2);
            tick();
        end
        resolve_oldest();
    endtask

    task automatic pipelined_round();
        int n;
        int sent;
        int target;
        n      = 2 + $urandom % 5;
        sent   = 0;
        target = responses + n;
        req_pc = random_pc();
        while (sent < n || responses < target) begin
            req_valid  = (sent < n);
            resp_ready = ($urandom % 3) != 0;  // stalls in random stretches
            tick();
            if (last_req_fire) begin
                sent++;
                req_pc = random_pc();
            end
        end
        while (log_pc.size() > 0) resolve_oldest();
    endtask

    task automatic flush_round();
        int sent;
        sent       = 0;
        resp_ready = 1'b0;
        req_pc     = random_pc();
        while (sent < 2) begin
            req_valid = 1'b1;
            tick();
            if (last_req_fire) begin
                sent++;
                req_pc = random_pc();
            end
        end
        if (!resp_valid) fail_now("no response held before the flush");
        resolve_pc           = resp_pc;       // mispredict the held prediction
        resolve_history      = resp_history;
        resolve_predicted    = resp_taken;
        resolve_gshare_taken = resp_gshare_taken;
        resolve_simple_taken = resp_simple_taken;
        resolve_taken        = !resp_taken;
        resolve_valid        = 1'b1;
        tick();
        check_equal("flush_resp_valid", 0, 32'(resp_valid));
        resp_ready = 1'b1;
        repeat (3) tick();                    // squashed entries must not appear
    endtask

    initial begin
        int sel;
        void'($urandom(32'hb2710718));
        reset = 1'b1;
        req_valid = 1'b0;
        req_pc = '0;
        resp_ready = 1'b0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_history = '0;
        resolve_taken = 1'b0;
        resolve_predicted = 1'b0;
        resolve_gshare_taken = 1'b0;
        resolve_simple_taken = 1'b0;
        for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
            ref_gshare[i] = 2'd0;
            ref_simple[i] = 2'd0;
            ref_meta[i]   = 2'd0;
        end
        model_history = '0;
        accepted = 0;
        responses = 0;
        dropped = 0;
        last_req_fire = 1'b0;
        first_resp = 1'b1;
        repair_pending = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        serial_round();                       // first prediction from reset state
        for (int r = 0; r < ROUNDS; r++) begin
            sel = $urandom % 20;
            if (sel < 12) serial_round();
            else if (sel < 17) pipelined_round();
            else flush_round();
        end
        if (accepted == responses + dropped) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("accepted %0d but answered %0d and flushed %0d",
                     accepted, responses, dropped);
            $display("TEST RESULT: FAIL");
            $fatal(1, "response count mismatch");
        end
    end

endmodule

//--- verif/tournament_predictor_assert.sv
`timescale 1ns/1ps

// protocol checks on the predictor ports
module tournament_predictor_assert (
    input logic              clock,
    input logic              reset,
    input logic              req_ready,
    input logic              resp_valid,
    input bp_pkg::pc_t       resp_pc,
    input logic              resp_taken,
    input logic              resp_gshare_taken,
    input logic              resp_simple_taken,
    input bp_pkg::history_t  resp_history,
    input logic              resp_ready,
    input logic              resolve_valid,
    input logic              resolve_taken,
    input logic              resolve_predicted
);

    logic mispredict;

    assign mispredict = resolve_valid && (resolve_taken != resolve_predicted);

    a_reset_empty: assert property (@(posedge clock) reset |=> !resp_valid)
        else $error("resp_valid high after reset");

    // held response frozen unless squashed
    a_stall_stable: assert property (@(posedge clock) disable iff (reset)
        resp_valid && !resp_ready && !mispredict |=>
            resp_valid && $stable(resp_pc) && $stable(resp_taken)
            && $stable(resp_gshare_taken) && $stable(resp_simple_taken)
            && $stable(resp_history))
        else $error("response changed while stalled");

    a_flush_clears: assert property (@(posedge clock) disable iff (reset)
        mispredict |=> !resp_valid)
        else $error("resp_valid survived a flush");

    a_flush_refuses: assert property (@(posedge clock) disable iff (reset)
        mispredict |-> !req_ready)
        else $error("req_ready high in a flush cycle");

endmodule

bind tournament_predictor tournament_predictor_assert i_assert (
    .clock             (clock),
    .reset             (reset),
    .req_ready         (req_ready),
    .resp_valid        (resp_valid),
    .resp_pc           (resp_pc),
    .resp_taken        (resp_taken),
    .resp_gshare_taken (resp_gshare_taken),
    .resp_simple_taken (resp_simple_taken),
    .resp_history      (resp_history),
    .resp_ready        (resp_ready),
    .resolve_valid     (resolve_valid),
    .resolve_taken     (resolve_taken),
    .resolve_predicted (resolve_predicted)
);

//--- rtl/tournament_predictor.sv
`timescale 1ns/1ps

// request stage -> core lookup -> response stage, resolve goes straight to the core
module tournament_predictor (
    input  logic              clock,
    input  logic              reset,

    // request port
    input  logic              req_valid,
    input  bp_pkg::pc_t       req_pc,
    output logic              req_ready,

    // response port
    output logic              resp_valid,
    output bp_pkg::pc_t       resp_pc,
    output logic              resp_taken,
    output logic              resp_gshare_taken,
    output logic              resp_simple_taken,
    output bp_pkg::history_t  resp_history,
    input  logic              resp_ready,

    // resolve port
    input  logic              resolve_valid,
    input  bp_pkg::pc_t       resolve_pc,
    input  bp_pkg::history_t  resolve_history,
    input  logic              resolve_taken,
    input  logic              resolve_predicted,
    input  logic              resolve_gshare_taken,
    input  logic              resolve_simple_taken
);

    import bp_pkg::*;

    logic     lookup_valid;
    pc_t      lookup_pc;
    logic     lookup_ready;
    logic     lookup_taken;
    logic     lookup_gshare_taken;
    logic     lookup_simple_taken;
    history_t lookup_history;
    logic     resp_free;
    logic     flush;           // mispredict, clears both stages

    bp_request_stage i_request_stage (
        .clock        (clock),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_pc       (req_pc),
        .req_ready    (req_ready),
        .flush        (flush),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .lookup_ready (lookup_ready)
    );

    bp_predictor_core i_predictor_core (
        .clock                (clock),
        .reset                (reset),
        .lookup_valid         (lookup_valid),
        .lookup_pc            (lookup_pc),
        .lookup_ready         (lookup_ready),
        .lookup_taken         (lookup_taken),
        .lookup_gshare_taken  (lookup_gshare_taken),
        .lookup_simple_taken  (lookup_simple_taken),
        .lookup_history       (lookup_history),
        .resp_free            (resp_free),
        .resolve_valid        (resolve_valid),
        .resolve_pc           (resolve_pc),
        .resolve_history      (resolve_history),
        .resolve_taken        (resolve_taken),
        .resolve_predicted    (resolve_predicted),
        .resolve_gshare_taken (resolve_gshare_taken),
        .resolve_simple_taken (resolve_simple_taken),
        .flush                (flush)
    );

    bp_response_stage i_response_stage (
        .clock               (clock),
        .reset               (reset),
        .flush               (flush),
        .lookup_valid        (lookup_valid),
        .lookup_pc           (lookup_pc),
        .lookup_taken        (lookup_taken),
        .lookup_gshare_taken (lookup_gshare_taken),
        .lookup_simple_taken (lookup_simple_taken),
        .lookup_history      (lookup_history),
        .resp_free           (resp_free),
        .resp_valid          (resp_valid),
        .resp_pc             (resp_pc),
        .resp_taken          (resp_taken),
        .resp_gshare_taken   (resp_gshare_taken),
        .resp_simple_taken   (resp_simple_taken),
        .resp_history        (resp_history),
        .resp_ready          (resp_ready)
    );

endmodule

//--- rtl/bp_response_stage.sv
`timescale 1ns/1ps

// one-entry output register, holds a prediction until fetch takes it
module bp_response_stage (
    input  logic              clock,
    input  logic              reset,
    input  logic              flush,

    // finished lookup from the core
    input  logic              lookup_valid,
    input  bp_pkg::pc_t       lookup_pc,
    input  logic              lookup_taken,
    input  logic              lookup_gshare_taken,
    input  logic              lookup_simple_taken,
    input  bp_pkg::history_t  lookup_history,
    output logic              resp_free,

    // fetch side
    output logic              resp_valid,
    output bp_pkg::pc_t       resp_pc,
    output logic              resp_taken,
    output logic              resp_gshare_taken,
    output logic              resp_simple_taken,
    output bp_pkg::history_t  resp_history,
    input  logic              resp_ready
);

    import bp_pkg::*;

    logic     entry_valid;
    pc_t      entry_pc;        // payload regs below have no reset
    logic     entry_taken;
    logic     entry_gshare_taken;
    logic     entry_simple_taken;
    history_t entry_history;

    // room when empty or draining this cycle
    assign resp_free = !entry_valid || resp_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= 1'b0;
        end else if (flush) begin
            entry_valid <= 1'b0;               // held prediction is squashed
        end else if (resp_free) begin
            entry_valid <= lookup_valid;
        end
    end

    // payload frozen while stalled
    always_ff @(posedge clock) begin
        if (resp_free && lookup_valid) begin
            entry_pc           <= lookup_pc;
            entry_taken        <= lookup_taken;
            entry_gshare_taken <= lookup_gshare_taken;
            entry_simple_taken <= lookup_simple_taken;
            entry_history      <= lookup_history;
        end
    end

    assign resp_valid        = entry_valid;
    assign resp_pc           = entry_pc;
    assign resp_taken        = entry_taken;
    assign resp_gshare_taken = entry_gshare_taken;
    assign resp_simple_taken = entry_simple_taken;
    assign resp_history      = entry_history;

endmodule

//--- rtl/bp_predictor_core.sv
`timescale 1ns/1ps
`include "bp_config.svh"

// tournament core: gshare + bimodal components, meta chooser, speculative ghr
module bp_predictor_core (
    input  logic              clock,
    input  logic              reset,

    // lookup request from the request stage
    input  logic              lookup_valid,
    input  bp_pkg::pc_t       lookup_pc,
    output logic              lookup_ready,

    // lookup result toward the response stage
    output logic              lookup_taken,
    output logic              lookup_gshare_taken,
    output logic              lookup_simple_taken,
    output bp_pkg::history_t  lookup_history,
    input  logic              resp_free,       // response stage can take an entry

    // resolve from the branch unit, no back-pressure
    input  logic              resolve_valid,
    input  bp_pkg::pc_t       resolve_pc,
    input  bp_pkg::history_t  resolve_history,
    input  logic              resolve_taken,   // actual outcome
    input  logic              resolve_predicted,
    input  logic              resolve_gshare_taken,
    input  logic              resolve_simple_taken,

    output logic              flush
);

    import bp_pkg::*;

    // pattern tables
    counter_t gshare_pht [`BP_PHT_ENTRIES];
    counter_t simple_pht [`BP_PHT_ENTRIES];
    counter_t meta_pht   [`BP_PHT_ENTRIES];  // msb set picks gshare

    history_t history;                       // speculative ghr

    // lookup side
    pht_index_t lookup_simple_idx;           // also the meta index
    pht_index_t lookup_gshare_idx;
    logic       lookup_fire;                 // lookup moves into the response stage

    // resolve side
    pht_index_t resolve_simple_idx;
    pht_index_t resolve_gshare_idx;
    logic       gshare_right;
    logic       simple_right;
    counter_t   gshare_next;
    counter_t   simple_next;
    counter_t   meta_next;
    history_t   repair_history;

    // one saturating step toward up/down
    function automatic counter_t sat_step(input counter_t ctr, input logic up);
        counter_t next_ctr;
        next_ctr = ctr;
        if (up && (ctr != COUNTER_MAX)) begin
            next_ctr = ctr + 2'd1;
        end else if (!up && (ctr != COUNTER_MIN)) begin
            next_ctr = ctr - 2'd1;
        end
        return next_ctr;
    endfunction

    // lookup, tables read live
    always_comb begin
        lookup_simple_idx   = lookup_pc[`BP_PHT_INDEX_BITS-1:0];
        lookup_gshare_idx   = lookup_pc[`BP_PHT_INDEX_BITS-1:0] ^ history;
        lookup_gshare_taken = gshare_pht[lookup_gshare_idx][1];
        lookup_simple_taken = simple_pht[lookup_simple_idx][1];
        // chooser msb decides which component drives the prediction
        lookup_taken   = meta_pht[lookup_simple_idx][1] ? lookup_gshare_taken
                                                        : lookup_simple_taken;
        lookup_history = history;            // history this prediction was made with
    end

    // consumed whenever the response stage has room
    assign lookup_ready = resp_free;
    assign lookup_fire  = lookup_valid && resp_free;

    // mispredict detect
    assign flush = resolve_valid && (resolve_taken != resolve_predicted);

    // training, indices rebuilt from what the response carried
    always_comb begin
        resolve_simple_idx = resolve_pc[`BP_PHT_INDEX_BITS-1:0];
        resolve_gshare_idx = resolve_pc[`BP_PHT_INDEX_BITS-1:0] ^ resolve_history;
        gshare_right = (resolve_gshare_taken == resolve_taken);
        simple_right = (resolve_simple_taken == resolve_taken);
        gshare_next  = sat_step(gshare_pht[resolve_gshare_idx], resolve_taken);
        simple_next  = sat_step(simple_pht[resolve_simple_idx], resolve_taken);
        // up toward gshare when only gshare was right, else down toward simple
        meta_next    = sat_step(meta_pht[resolve_simple_idx], gshare_right);
        // history as if the branch had been predicted correctly
        repair_history = {resolve_history[`BP_HISTORY_BITS-2:0], resolve_taken};
    end

    // table writes land at the resolve edge, same-cycle lookup sees old value
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
                gshare_pht[i] <= COUNTER_MIN;
                simple_pht[i] <= COUNTER_MIN;
                meta_pht[i]   <= COUNTER_MIN;
            end
        end else if (resolve_valid) begin
            gshare_pht[resolve_gshare_idx] <= gshare_next;  // both components always train
            simple_pht[resolve_simple_idx] <= simple_next;
            if (gshare_right != simple_right) begin
                meta_pht[resolve_simple_idx] <= meta_next;  // only when they disagree in result
            end
        end
    end

    // ghr: repair beats the speculative shift
    always_ff @(posedge clock) begin
        if (reset) begin
            history <= '0;
        end else if (flush) begin
            history <= repair_history;
        end else if (lookup_fire) begin
            history <= {history[`BP_HISTORY_BITS-2:0], lookup_taken};
        end
    end

endmodule

//--- rtl/bp_request_stage.sv
`timescale 1ns/1ps

// one-entry skid between fetch and the table lookup
module bp_request_stage (
    input  logic          clock,
    input  logic          reset,

    // fetch side
    input  logic          req_valid,
    input  bp_pkg::pc_t   req_pc,
    output logic          req_ready,

    // mispredict from the core
    input  logic          flush,

    // core side
    output logic          lookup_valid,
    output bp_pkg::pc_t   lookup_pc,
    input  logic          lookup_ready
);

    import bp_pkg::*;

    logic entry_valid; // stage holds a request
    pc_t  entry_pc;    // payload, no reset needed

    logic accept;      // fetch handshake this cycle

    // free when empty or when the core takes the entry this cycle
    // a flush cycle never takes a new request
    always_comb begin
        req_ready = (!entry_valid || lookup_ready) && !flush;
    end

    assign accept = req_valid && req_ready;

    // occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= 1'b0;
        end else if (flush) begin
            entry_valid <= 1'b0;           // drop the in-flight request
        end else if (req_ready) begin
            entry_valid <= req_valid;      // refill or go empty
        end
    end

    // payload only moves on a handshake
    always_ff @(posedge clock) begin
        if (accept) begin
            entry_pc <= req_pc;
        end
    end

    assign lookup_valid = entry_valid;
    assign lookup_pc    = entry_pc;

endmodule

//--- rtl/bp_pkg.sv
`include "bp_config.svh"

package bp_pkg;

    // fetch address of a branch
    typedef logic [`BP_PC_BITS-1:0] pc_t;

    // global history, bit 0 is the youngest branch
    typedef logic [`BP_HISTORY_BITS-1:0] history_t;

    // index into gshare, simple or meta table
    typedef logic [`BP_PHT_INDEX_BITS-1:0] pht_index_t;

    // 2-bit saturating counter, msb set = taken (meta: gshare chosen)
    typedef logic [1:0] counter_t;

    localparam counter_t COUNTER_MIN = 2'd0; // strongly not taken, also the reset value
    localparam counter_t COUNTER_MAX = 2'd3; // strongly taken

endpackage

//--- include/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// global history length, newest outcome lands in bit 0
`define BP_HISTORY_BITS 8

// program counter width
`define BP_PC_BITS 32

// pattern table index width, gshare XORs pc bits with the full history
`define BP_PHT_INDEX_BITS `BP_HISTORY_BITS

// counters per pattern table
`define BP_PHT_ENTRIES (1 << `BP_PHT_INDEX_BITS)

`endif
